/* lq_consts.svh */
`ifndef LQ_CONSTS_SVH
`define LQ_CONSTS_SVH

// queue geometry
`define LQ_SIZE 16
`define LQ_WIDTH 4

// rob index width, wrap bit not counted
`define ROB_WIDTH 6

`define PADDR_SIZE 32
`define XLEN 64

// bytes in one data word and the offset bits inside it
`define DATA_BYTES 8
`define BYTE_OFS_WIDTH 3

// loads retired per cycle
`define COMMIT_WIDTH 2

// architectural register index
`define REG_WIDTH 5

`endif

/* source/lq_pkg.sv */
`include "lq_consts.svh"

package lq_pkg;

    typedef struct packed {
        logic dir;
        logic [`LQ_WIDTH-1:0] idx;
    } lq_idx_t;

    typedef struct packed {
        logic dir;
        logic [`ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } load_size_e;

    // forwarded bytes sit in their memory lanes, same as refill data
    typedef struct packed {
        lq_idx_t lq_idx;
        rob_idx_t rob_idx;
        logic [`REG_WIDTH-1:0] rd;
        load_size_e size;
        logic uext;
        logic [`PADDR_SIZE-1:0] addr;
        logic [`DATA_BYTES-1:0] fwd_mask;
        logic [`XLEN-1:0] fwd_data;
        logic miss;
    } lq_issue_t;

    typedef struct packed {
        lq_idx_t lq_idx;
        logic [`XLEN-1:0] data;
    } lq_refill_t;

    typedef struct packed {
        logic [`PADDR_SIZE-1:0] addr;
        logic [`DATA_BYTES-1:0] mask;
        lq_idx_t lq_idx;
    } lq_store_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        logic [`REG_WIDTH-1:0] rd;
        logic [`XLEN-1:0] res;
    } lq_wb_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        lq_idx_t lq_idx;
    } lq_vio_t;

    // true when a is later in program order than b
    function automatic logic rob_younger(rob_idx_t a, rob_idx_t b);
        return (a.dir == b.dir) ? (a.idx > b.idx) : (a.idx < b.idx);
    endfunction

endpackage

/* source/lq_pointers.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module lq_pointers
    import lq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic dis_valid_i,
    input  logic [1:0] commit_num_i,
    input  logic redirect_valid_i,
    input  logic [`LQ_WIDTH:0] survivor_count_i,
    output lq_idx_t head_o,
    output lq_idx_t tail_o,
    output logic full_o
);
    lq_idx_t head;
    lq_idx_t tail;
    lq_idx_t head_n;
    lq_idx_t tail_n;
    lq_idx_t recovered_tail;
    logic redirect_q;
    logic ring_full;

    // dir is the bit above idx, so a plain add flips it on wrap
    assign head_n = lq_idx_t'(head + {{(`LQ_WIDTH-1){1'b0}}, commit_num_i});
    assign tail_n = lq_idx_t'(tail + 1'b1);

    // survivors are contiguous from head once the flush has landed
    assign recovered_tail = lq_idx_t'(head + survivor_count_i);

    assign ring_full = (head.idx == tail.idx) && (head.dir != tail.dir);

    // tail is not trustworthy until it is recovered
    assign full_o = ring_full | redirect_q;

    assign head_o = head;
    assign tail_o = tail;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= redirect_valid_i;
            head <= head_n;
            if (redirect_q) begin
                tail <= recovered_tail;
            end else if (dis_valid_i && !redirect_valid_i) begin
                tail <= tail_n;
            end
        end
    end

endmodule

/* source/lq_entry_table.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module lq_entry_table
    import lq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic dis_valid_i,
    input  rob_idx_t dis_rob_i,
    input  lq_idx_t tail_i,
    input  lq_idx_t head_i,
    input  logic issue_valid_i,
    input  lq_issue_t issue_i,
    input  logic refill_valid_i,
    input  lq_refill_t refill_i,
    input  logic [1:0] commit_num_i,
    input  logic redirect_valid_i,
    input  rob_idx_t redirect_rob_i,
    output logic [`LQ_SIZE-1:0] valid_o,
    output logic [`LQ_SIZE-1:0] addressed_o,
    output rob_idx_t [`LQ_SIZE-1:0] entry_rob_o,
    output logic [`LQ_SIZE-1:0][`PADDR_SIZE-1:0] entry_addr_o,
    output logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0] entry_mask_o,
    output logic [`LQ_WIDTH:0] survivor_count_o,
    output logic wb_valid_o,
    output lq_wb_t wb_o
);
    logic [`LQ_SIZE-1:0] valid, addressed, miss, data_ready, written;
    logic [`LQ_SIZE-1:0] alloc, commit_clr, flush, ready;
    rob_idx_t [`LQ_SIZE-1:0] rob;
    logic [`LQ_SIZE-1:0][`PADDR_SIZE-1:0] addr;
    logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0] mask;
    logic [`LQ_SIZE-1:0] uext;
    logic [`REG_WIDTH-1:0] rd [`LQ_SIZE];
    load_size_e size [`LQ_SIZE];
    logic [`DATA_BYTES-1:0] fwd_mask [`LQ_SIZE];
    logic [`XLEN-1:0] fwd_data [`LQ_SIZE];
    logic [`XLEN-1:0] result [`LQ_SIZE];

    logic [`LQ_WIDTH-1:0] rf_idx, wb_idx;
    logic [`BYTE_OFS_WIDTH-1:0] rf_ofs;
    logic [`XLEN-1:0] rf_merged, rf_shifted, rf_result;
    logic redirect_q;
    logic wb_fire;

    function automatic logic [`DATA_BYTES-1:0] size_mask(load_size_e sz);
        case (sz)
            SIZE_BYTE: return 8'h01;
            SIZE_HALF: return 8'h03;
            SIZE_WORD: return 8'h0f;
            default:   return 8'hff;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] extend(logic [`XLEN-1:0] raw, load_size_e sz,
                                                 logic u);
        logic [`XLEN-1:0] res;
        case (sz)
            SIZE_BYTE: res = u ? {56'b0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
            SIZE_HALF: res = u ? {48'b0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            SIZE_WORD: res = u ? {32'b0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default:   res = raw;
        endcase
        return res;
    endfunction

    // no allocation while the ring is being cut back
    assign alloc = (dis_valid_i && !redirect_valid_i) ? (`LQ_SIZE'(1) << tail_i.idx) : '0;

    always_comb begin
        logic [`LQ_WIDTH-1:0] pos;
        commit_clr = '0;
        for (int j = 0; j < `COMMIT_WIDTH; j++) begin
            pos = head_i.idx + `LQ_WIDTH'(j);
            if (j < int'(commit_num_i)) begin
                commit_clr[pos] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            flush[i] = redirect_valid_i && rob_younger(rob[i], redirect_rob_i);
        end
    end

    // refill merge: forwarded store bytes win over cache bytes
    assign rf_idx = refill_i.lq_idx.idx;
    always_comb begin
        for (int b = 0; b < `DATA_BYTES; b++) begin
            rf_merged[b*8 +: 8] = fwd_mask[rf_idx][b] ? fwd_data[rf_idx][b*8 +: 8]
                                                      : refill_i.data[b*8 +: 8];
        end
    end
    assign rf_ofs = addr[rf_idx][`BYTE_OFS_WIDTH-1:0];
    assign rf_shifted = rf_merged >> {rf_ofs, 3'b000};
    assign rf_result = extend(rf_shifted, size[rf_idx], uext[rf_idx]);

    // lowest ready index wins
    assign ready = valid & miss & data_ready & ~written;
    always_comb begin
        wb_idx = '0;
        for (int i = `LQ_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                wb_idx = `LQ_WIDTH'(i);
            end
        end
    end
    assign wb_fire = (|ready) && !redirect_valid_i && !redirect_q;

    always_comb begin
        survivor_count_o = '0;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            survivor_count_o = survivor_count_o + (`LQ_WIDTH+1)'(valid[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            addressed <= '0;
            miss <= '0;
            data_ready <= '0;
            written <= '0;
            redirect_q <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            redirect_q <= redirect_valid_i;
            wb_valid_o <= wb_fire;
            valid <= (valid | alloc) & ~commit_clr & ~flush;
            addressed <= addressed & ~alloc;
            miss <= miss & ~alloc;
            data_ready <= data_ready & ~alloc;
            written <= written & ~alloc;
            if (issue_valid_i) begin
                addressed[issue_i.lq_idx.idx] <= 1'b1;
                miss[issue_i.lq_idx.idx] <= issue_i.miss;
            end
            if (refill_valid_i) begin
                data_ready[rf_idx] <= 1'b1;
            end
            if (wb_fire) begin
                written[wb_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dis_valid_i) begin
            rob[tail_i.idx] <= dis_rob_i;
        end
        if (issue_valid_i) begin
            rd[issue_i.lq_idx.idx] <= issue_i.rd;
            size[issue_i.lq_idx.idx] <= issue_i.size;
            uext[issue_i.lq_idx.idx] <= issue_i.uext;
            addr[issue_i.lq_idx.idx] <= issue_i.addr;
            mask[issue_i.lq_idx.idx] <= size_mask(issue_i.size)
                                        << issue_i.addr[`BYTE_OFS_WIDTH-1:0];
            fwd_mask[issue_i.lq_idx.idx] <= issue_i.fwd_mask;
            fwd_data[issue_i.lq_idx.idx] <= issue_i.fwd_data;
        end
        if (refill_valid_i) begin
            result[rf_idx] <= rf_result;
        end
        if (wb_fire) begin
            wb_o.rob_idx <= rob[wb_idx];
            wb_o.rd <= rd[wb_idx];
            wb_o.res <= result[wb_idx];
        end
    end

    assign valid_o = valid;
    assign addressed_o = addressed;
    assign entry_rob_o = rob;
    assign entry_addr_o = addr;
    assign entry_mask_o = mask;

endmodule

/* source/lq_violation_check.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module lq_violation_check
    import lq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic store_valid_i,
    input  lq_store_t store_i,
    input  lq_idx_t head_i,
    input  lq_idx_t tail_i,
    input  logic [`LQ_SIZE-1:0] valid_i,
    input  logic [`LQ_SIZE-1:0] addressed_i,
    input  rob_idx_t [`LQ_SIZE-1:0] entry_rob_i,
    input  logic [`LQ_SIZE-1:0][`PADDR_SIZE-1:0] entry_addr_i,
    input  logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0] entry_mask_i,
    output logic vio_valid_o,
    output lq_vio_t vio_o
);
    logic [`LQ_SIZE-1:0] head_below, store_below, age_window, overlap, hit;
    logic span;
    logic overflow;
    logic found;
    rob_idx_t oldest_rob;
    lq_idx_t oldest_lq;

    // slots below head and below the store position
    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            head_below[i] = i < head_i.idx;
            store_below[i] = i < store_i.lq_idx.idx;
        end
    end

    // slots from the store position onward, counted from head
    assign span = head_i.dir ^ store_i.lq_idx.dir;
    assign age_window = ~({`LQ_SIZE{span}} ^ head_below ^ store_below);

    // store sits past the tail, so no load is younger
    assign overflow = (store_i.lq_idx.dir == tail_i.dir) ? (store_i.lq_idx.idx > tail_i.idx)
                                                         : (store_i.lq_idx.idx < tail_i.idx);

    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            overlap[i] = (entry_addr_i[i][`PADDR_SIZE-1:`BYTE_OFS_WIDTH]
                          == store_i.addr[`PADDR_SIZE-1:`BYTE_OFS_WIDTH])
                         && (|(entry_mask_i[i] & store_i.mask));
        end
    end

    assign hit = valid_i & addressed_i & overlap & age_window & {`LQ_SIZE{~overflow}};

    // oldest by rob index, slot dir rebuilt from head
    always_comb begin
        found = 1'b0;
        oldest_rob = '0;
        oldest_lq = '0;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            if (hit[i] && (!found || rob_younger(oldest_rob, entry_rob_i[i]))) begin
                found = 1'b1;
                oldest_rob = entry_rob_i[i];
                oldest_lq.idx = `LQ_WIDTH'(i);
                oldest_lq.dir = (`LQ_WIDTH'(i) >= head_i.idx) ? head_i.dir : ~head_i.dir;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vio_valid_o <= 1'b0;
        end else begin
            vio_valid_o <= store_valid_i && found;
        end
    end

    always_ff @(posedge clk) begin
        vio_o.rob_idx <= oldest_rob;
        vio_o.lq_idx <= oldest_lq;
    end

endmodule

/* source/load_queue.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module load_queue
    import lq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic dis_valid_i,
    input  rob_idx_t dis_rob_i,
    input  logic issue_valid_i,
    input  lq_issue_t issue_i,
    input  logic refill_valid_i,
    input  lq_refill_t refill_i,
    input  logic [1:0] commit_num_i,
    input  logic redirect_valid_i,
    input  rob_idx_t redirect_rob_i,
    input  logic store_valid_i,
    input  lq_store_t store_i,
    output logic full_o,
    output lq_idx_t lq_idx_o,
    output logic wb_valid_o,
    output lq_wb_t wb_o,
    output logic vio_valid_o,
    output lq_vio_t vio_o
);
    lq_idx_t head;
    lq_idx_t tail;
    logic [`LQ_SIZE-1:0] entry_valid;
    logic [`LQ_SIZE-1:0] entry_addressed;
    rob_idx_t [`LQ_SIZE-1:0] entry_rob;
    logic [`LQ_SIZE-1:0][`PADDR_SIZE-1:0] entry_addr;
    logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0] entry_mask;
    logic [`LQ_WIDTH:0] survivor_count;

    // next dispatch gets the current tail
    assign lq_idx_o = tail;

    lq_pointers u_pointers (
        .clk,
        .rst,
        .dis_valid_i,
        .commit_num_i,
        .redirect_valid_i,
        .survivor_count_i (survivor_count),
        .head_o           (head),
        .tail_o           (tail),
        .full_o
    );

    lq_entry_table u_entry_table (
        .clk,
        .rst,
        .dis_valid_i,
        .dis_rob_i,
        .tail_i           (tail),
        .head_i           (head),
        .issue_valid_i,
        .issue_i,
        .refill_valid_i,
        .refill_i,
        .commit_num_i,
        .redirect_valid_i,
        .redirect_rob_i,
        .valid_o          (entry_valid),
        .addressed_o      (entry_addressed),
        .entry_rob_o      (entry_rob),
        .entry_addr_o     (entry_addr),
        .entry_mask_o     (entry_mask),
        .survivor_count_o (survivor_count),
        .wb_valid_o,
        .wb_o
    );

    lq_violation_check u_violation_check (
        .clk,
        .rst,
        .store_valid_i,
        .store_i,
        .head_i           (head),
        .tail_i           (tail),
        .valid_i          (entry_valid),
        .addressed_i      (entry_addressed),
        .entry_rob_i      (entry_rob),
        .entry_addr_i     (entry_addr),
        .entry_mask_i     (entry_mask),
        .vio_valid_o,
        .vio_o
    );

endmodule

/* verification/load_queue_properties.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module load_queue_properties
    import lq_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic dis_valid_i,
    input logic redirect_valid_i,
    input logic store_valid_i,
    input logic full_i,
    input lq_idx_t lq_idx_i,
    input logic wb_valid_i,
    input logic vio_valid_i
);
    int unsigned fail_count = 0;

    // outputs idle during reset and on the first edge after it
    reset_idle: assert property (@(posedge clk) (rst || $past(rst)) |->
        (!full_i && !wb_valid_i && !vio_valid_i && lq_idx_i == '0))
    else begin
        fail_count++;
        $error("outputs not idle around reset");
    end

    dispatch_step: assert property (@(posedge clk) disable iff (rst)
        (dis_valid_i && !redirect_valid_i && !full_i) |=>
        (lq_idx_i == lq_idx_t'($past(lq_idx_i) + 5'd1)))
    else begin
        fail_count++;
        $error("tail did not advance by one after dispatch");
    end

    vio_after_store: assert property (@(posedge clk) disable iff (rst)
        vio_valid_i |-> $past(store_valid_i))
    else begin
        fail_count++;
        $error("violation raised without a store check one cycle earlier");
    end

endmodule

/* verification/load_queue_tb.sv */
`timescale 1ns/100ps
`include "lq_consts.svh"

module load_queue_tb
    import lq_pkg::*;
();
    logic clk;
    logic rst;
    logic dis_valid_i;
    rob_idx_t dis_rob_i;
    logic issue_valid_i;
    lq_issue_t issue_i;
    logic refill_valid_i;
    lq_refill_t refill_i;
    logic [1:0] commit_num_i;
    logic redirect_valid_i;
    rob_idx_t redirect_rob_i;
    logic store_valid_i;
    lq_store_t store_i;
    logic full_o;
    lq_idx_t lq_idx_o;
    logic wb_valid_o;
    lq_wb_t wb_o;
    logic vio_valid_o;
    lq_vio_t vio_o;

    int tests = 0;
    int checks = 0;
    int fails = 0;
    lq_idx_t head_model = '0;
    lq_idx_t tail_model = '0;
    rob_idx_t next_rob = '0;

    load_queue dut0 (.*);

    bind load_queue load_queue_properties props0 (
        .clk              (clk),
        .rst              (rst),
        .dis_valid_i      (dis_valid_i),
        .redirect_valid_i (redirect_valid_i),
        .store_valid_i    (store_valid_i),
        .full_i           (full_o),
        .lq_idx_i         (lq_idx_o),
        .wb_valid_i       (wb_valid_o),
        .vio_valid_i      (vio_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        value_match: assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fails++;
        end
    endtask

    task automatic report_test(string name);
        tests++;
        $display("%s finished, %0d failures so far", name, fails);
    endtask

    task automatic dispatch(output lq_idx_t slot, output rob_idx_t rob);
        check_value("lq_idx_o", lq_idx_o, tail_model);
        slot = tail_model;
        rob = next_rob;
        dis_valid_i = 1'b1;
        dis_rob_i = next_rob;
        next_rob = rob_idx_t'(next_rob + 7'd1);
        tail_model = lq_idx_t'(tail_model + 5'd1);
        next_cycle();
        dis_valid_i = 1'b0;
    endtask

    task automatic issue_load(lq_idx_t slot, rob_idx_t rob, load_size_e size, logic uext,
                              logic [31:0] addr, logic [7:0] fmask, logic [63:0] fdata,
                              logic miss);
        issue_valid_i = 1'b1;
        issue_i = '{lq_idx: slot, rob_idx: rob, rd: rob.idx[`REG_WIDTH-1:0], size: size,
                    uext: uext, addr: addr, fwd_mask: fmask, fwd_data: fdata, miss: miss};
        next_cycle();
        issue_valid_i = 1'b0;
    endtask

    task automatic refill(lq_idx_t slot, logic [63:0] data);
        refill_valid_i = 1'b1;
        refill_i = '{lq_idx: slot, data: data};
        next_cycle();
        refill_valid_i = 1'b0;
    endtask

    task automatic commit(logic [1:0] num);
        commit_num_i = num;
        head_model = lq_idx_t'(head_model + 5'(num));
        next_cycle();
        commit_num_i = 2'd0;
    endtask

    task automatic wait_writeback(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < 20 && !seen; n++) begin
            next_cycle();
            seen = wb_valid_o;
        end
        if (!seen) begin
            $display("Timeout: no writeback within 20 cycles");
            fails++;
        end
    endtask

    task automatic expect_no_writeback(int cycles);
        for (int n = 0; n < cycles; n++) begin
            next_cycle();
            check_value("wb_valid_o", wb_valid_o, 1'b0);
        end
    endtask

    task automatic store_check(logic [31:0] addr, logic [7:0] mask, lq_idx_t pos,
                               logic vio_expected, lq_idx_t exp_slot, rob_idx_t exp_rob);
        store_valid_i = 1'b1;
        store_i = '{addr: addr, mask: mask, lq_idx: pos};
        next_cycle();
        store_valid_i = 1'b0;
        check_value("vio_valid_o", vio_valid_o, vio_expected);
        if (vio_expected) begin
            check_value("vio_o.lq_idx", vio_o.lq_idx, exp_slot);
            check_value("vio_o.rob_idx", vio_o.rob_idx, exp_rob);
        end
    endtask

    // store bytes win per lane, then take size bytes from the offset
    function automatic logic [63:0] expected_load(logic [7:0] fmask, logic [63:0] fdata,
                                                  logic [63:0] cdata, logic [2:0] ofs,
                                                  load_size_e size, logic uext);
        logic [7:0] lanes [8];
        logic [63:0] res;
        int n;
        n = 1 << int'(size);
        res = '0;
        for (int b = 0; b < 8; b++) begin
            lanes[b] = fmask[b] ? fdata[b*8 +: 8] : cdata[b*8 +: 8];
        end
        for (int b = 0; b < 8; b++) begin
            if (b < n) begin
                res[b*8 +: 8] = lanes[int'(ofs) + b];
            end else if (!uext && lanes[int'(ofs) + n - 1][7]) begin
                res[b*8 +: 8] = 8'hff;
            end
        end
        return res;
    endfunction

    initial begin
        lq_idx_t slot_a;
        lq_idx_t slot_b;
        lq_idx_t slot_c;
        lq_idx_t store_pos;
        rob_idx_t rob_a;
        rob_idx_t rob_b;
        rob_idx_t rob_c;
        load_size_e sz;
        logic ue;
        logic seen;
        logic [2:0] ofs;
        logic [7:0] fmask;
        logic [31:0] base;
        logic [63:0] fdata;
        logic [63:0] cdata;
        int total;
        void'($urandom(32'hfdfc_44df));
        rst = 1'b1;
        dis_valid_i = 1'b0;
        dis_rob_i = '0;
        issue_valid_i = 1'b0;
        issue_i = '0;
        refill_valid_i = 1'b0;
        refill_i = '0;
        commit_num_i = 2'd0;
        redirect_valid_i = 1'b0;
        redirect_rob_i = '0;
        store_valid_i = 1'b0;
        store_i = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        next_cycle();

        check_value("full_o", full_o, 1'b0);
        check_value("wb_valid_o", wb_valid_o, 1'b0);
        check_value("vio_valid_o", vio_valid_o, 1'b0);
        check_value("lq_idx_o", lq_idx_o, '0);
        report_test("reset state");

        for (int k = 0; k < `LQ_SIZE; k++) begin
            dispatch(slot_a, rob_a);
        end
        check_value("full_o", full_o, 1'b1);
        commit(2'd2);
        check_value("full_o", full_o, 1'b0);
        // these two land with the wrap bit set
        dispatch(slot_a, rob_a);
        dispatch(slot_b, rob_b);
        check_value("full_o", full_o, 1'b1);
        repeat (`LQ_SIZE / 2) commit(2'd2);
        check_value("full_o", full_o, 1'b0);
        report_test("allocation and wrap");

        for (int k = 0; k < 4; k++) begin
            dispatch(slot_a, rob_a);
            sz = load_size_e'($urandom_range(0, 3));
            ue = 1'($urandom);
            ofs = 3'($urandom) & ~3'((1 << int'(sz)) - 1);
            base = $urandom & 32'hffff_fff8;
            fmask = 8'($urandom);
            fdata = {$urandom, $urandom};
            cdata = {$urandom, $urandom};
            issue_load(slot_a, rob_a, sz, ue, base | 32'(ofs), fmask, fdata, 1'b1);
            refill(slot_a, cdata);
            wait_writeback(seen);
            if (seen) begin
                check_value("wb_o.rob_idx", wb_o.rob_idx, rob_a);
                check_value("wb_o.rd", wb_o.rd, rob_a.idx[`REG_WIDTH-1:0]);
                check_value("wb_o.res", wb_o.res,
                            expected_load(fmask, fdata, cdata, ofs, sz, ue));
            end
            expect_no_writeback(4);
            commit(2'd1);
        end
        dispatch(slot_b, rob_b);
        issue_load(slot_b, rob_b, SIZE_DOUBLE, 1'b0, base, 8'h00, '0, 1'b0);
        expect_no_writeback(6);
        commit(2'd1);
        report_test("refill writeback");

        fdata = {$urandom, $urandom};
        cdata = {$urandom, $urandom};
        dispatch(slot_a, rob_a);
        dispatch(slot_b, rob_b);
        issue_load(slot_a, rob_a, SIZE_DOUBLE, 1'b0, base, 8'h00, '0, 1'b1);
        issue_load(slot_b, rob_b, SIZE_DOUBLE, 1'b0, base + 32'd8, 8'h00, '0, 1'b1);
        // redirect at the youngest load holds writeback so both refills pile up
        redirect_valid_i = 1'b1;
        redirect_rob_i = rob_b;
        refill_valid_i = 1'b1;
        refill_i = '{lq_idx: slot_b, data: cdata};
        next_cycle();
        redirect_valid_i = 1'b0;
        refill_valid_i = 1'b0;
        refill(slot_a, fdata);
        wait_writeback(seen);
        if (seen) begin
            check_value("wb_o.rob_idx", wb_o.rob_idx, rob_a);
            check_value("wb_o.res", wb_o.res, fdata);
            next_cycle();
            check_value("wb_valid_o", wb_valid_o, 1'b1);
            check_value("wb_o.rob_idx", wb_o.rob_idx, rob_b);
            check_value("wb_o.res", wb_o.res, cdata);
        end
        expect_no_writeback(4);
        commit(2'd2);
        report_test("writeback order");

        dispatch(slot_a, rob_a);
        dispatch(slot_b, rob_b);
        dispatch(slot_c, rob_c);
        issue_load(slot_c, rob_c, SIZE_WORD, 1'b0, base, 8'h00, '0, 1'b1);
        redirect_valid_i = 1'b1;
        redirect_rob_i = rob_b;
        refill_valid_i = 1'b1;
        refill_i = '{lq_idx: slot_c, data: cdata};
        next_cycle();
        redirect_valid_i = 1'b0;
        refill_valid_i = 1'b0;
        check_value("full_o", full_o, 1'b1);
        next_cycle();
        check_value("full_o", full_o, 1'b0);
        expect_no_writeback(6);
        tail_model = lq_idx_t'(head_model + 5'd2);
        next_rob = rob_idx_t'(rob_b + 7'd1);
        dispatch(slot_c, rob_c);
        commit(2'd2);
        commit(2'd1);
        report_test("redirect flush");

        base = $urandom & 32'hffff_fff8;
        dispatch(slot_a, rob_a);
        store_pos = tail_model;
        dispatch(slot_b, rob_b);
        dispatch(slot_c, rob_c);
        issue_load(slot_a, rob_a, SIZE_WORD, 1'b0, base, 8'h00, '0, 1'b0);
        issue_load(slot_b, rob_b, SIZE_WORD, 1'b0, base, 8'h00, '0, 1'b0);
        issue_load(slot_c, rob_c, SIZE_WORD, 1'b0, base, 8'h00, '0, 1'b0);
        store_check(base, 8'h0c, store_pos, 1'b1, slot_b, rob_b);
        store_check(base, 8'hf0, store_pos, 1'b0, slot_b, rob_b);
        store_check(base + 32'd8, 8'h0f, store_pos, 1'b0, slot_b, rob_b);
        store_check(base, 8'h0f, tail_model, 1'b0, slot_b, rob_b);
        commit(2'd2);
        commit(2'd1);
        report_test("store violation");

        total = fails + int'(dut0.props0.fail_count);
        $display("%0d tests, %0d checks, %0d failures", tests, checks, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* load_queue.f */
+incdir+.
source/lq_pkg.sv
source/lq_pointers.sv
source/lq_entry_table.sv
source/lq_violation_check.sv
source/load_queue.sv
verification/load_queue_properties.sv
verification/load_queue_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = load_queue_tb
FILELIST  = load_queue.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
